/* Bender.yml */
package:
  name: rv32i_pipe

sources:
  - rtl/core_types_pkg.sv
  - rtl/rv_isa_pkg.sv
  - rtl/instr_mem.sv
  - rtl/decoder.sv
  - rtl/regfile.sv
  - rtl/alu.sv
  - rtl/data_mem.sv
  - rtl/hazard_unit.sv
  - rtl/core.sv
  - target: test
    files:
      - dv/core_properties.sv
      - dv/core_tb.sv

/* dv/core_properties.sv */
`timescale 1ns/1ns

module core_properties (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      run_i,
	input logic                      imem_we_i,
	input logic                      wb_valid_o,
	input core_types_pkg::reg_addr_t wb_rd_o,
	input logic                      st_valid_o,
	input core_types_pkg::pc_t       st_addr_o
);

	// x0 writes stay invisible
	assert property (@(posedge clk) disable iff (!rst_n) wb_valid_o |-> wb_rd_o != '0)
		else $error("writeback port shows a write to x0");

	assert property (@(posedge clk) disable iff (!rst_n) st_valid_o |-> st_addr_o[1:0] == 2'b00)
		else $error("store address is not word aligned");

	// program load only while halted
	assert property (@(posedge clk) disable iff (!rst_n) run_i |-> !imem_we_i)
		else $error("instruction memory written while the core runs");

	assert property (@(posedge clk) $rose(rst_n) |-> (!wb_valid_o && !st_valid_o))
		else $error("valid output high right after reset release");

endmodule

bind core core_properties i_core_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.run_i      (run_i),
	.imem_we_i  (imem_we_i),
	.wb_valid_o (wb_valid_o),
	.wb_rd_o    (wb_rd_o),
	.st_valid_o (st_valid_o),
	.st_addr_o  (st_addr_o)
);

/* dv/core_tb.sv */
`timescale 1ns/1ns

module core_tb;
	import core_types_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      run;
	logic      imem_we;
	imem_idx_t imem_addr;
	word_t     imem_wdata;
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;
	logic      st_valid;
	pc_t       st_addr;
	word_t     st_data;

	// program words and the events they should retire, in program order
	word_t prog [$];
	logic  exp_is_store [$];
	pc_t   exp_key [$];
	word_t exp_val [$];
	string exp_name [$];
	int    prog_n = 0;
	int    seed = 32'hd0dc8da4;
	int    err_count = 0;
	word_t a;
	word_t b;

	core i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.run_i        (run),
		.imem_we_i    (imem_we),
		.imem_addr_i  (imem_addr),
		.imem_wdata_i (imem_wdata),
		.wb_valid_o   (wb_valid),
		.wb_rd_o      (wb_rd),
		.wb_data_o    (wb_data),
		.st_valid_o   (st_valid),
		.st_addr_o    (st_addr),
		.st_data_o    (st_data)
	);

	always #4 clk = ~clk;

	// rv32i encodings, opcodes taken from the isa manual
	function automatic word_t rtype_instr(input logic [6:0] f7, input logic [2:0] f3,
			input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t addi_instr(input reg_addr_t rd, input reg_addr_t rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic word_t lw_instr(input reg_addr_t rd, input reg_addr_t rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic word_t sw_instr(input reg_addr_t rs2, input reg_addr_t rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// offset in bytes, bit 0 dropped by the format
	function automatic word_t beq_instr(input reg_addr_t rs1, input reg_addr_t rs2,
			input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic expect_wb(input string name, input reg_addr_t rd, input word_t val);
		exp_is_store.push_back(1'b0);
		exp_key.push_back(pc_t'(rd));
		exp_val.push_back(val);
		exp_name.push_back(name);
	endtask

	task automatic expect_store(input string name, input pc_t addr, input word_t val);
		exp_is_store.push_back(1'b1);
		exp_key.push_back(addr);
		exp_val.push_back(val);
		exp_name.push_back(name);
	endtask

	task automatic build_tests();
		logic [10:0] ra;
		logic [10:0] rb;
		ra = 11'($random(seed));
		rb = 11'($random(seed));
		// a is never negative and b always is, so a != b and b < a signed
		a = {21'b0, ra};
		b = -({21'b0, rb} + 32'd1);
		prog.push_back(addi_instr(5'd1, 5'd0, a[11:0]));
		prog.push_back(addi_instr(5'd2, 5'd0, b[11:0]));
		prog.push_back(rtype_instr(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
		prog.push_back(rtype_instr(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1));
		prog.push_back(rtype_instr(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2));
		prog.push_back(rtype_instr(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2));
		prog.push_back(rtype_instr(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2));
		prog.push_back(rtype_instr(7'b0000000, 3'b010, 5'd8, 5'd2, 5'd1));
		prog.push_back(rtype_instr(7'b0000000, 3'b010, 5'd9, 5'd1, 5'd2));
		prog.push_back(sw_instr(5'd3, 5'd0, 12'd8));
		prog.push_back(lw_instr(5'd10, 5'd0, 12'd8));
		// load-use pair
		prog.push_back(rtype_instr(7'b0000000, 3'b000, 5'd11, 5'd10, 5'd1));
		prog.push_back(beq_instr(5'd1, 5'd2, 13'd8));
		prog.push_back(addi_instr(5'd12, 5'd0, 12'd5));
		// taken, lands on word 17
		prog.push_back(beq_instr(5'd12, 5'd12, 13'd12));
		prog.push_back(addi_instr(5'd13, 5'd0, 12'd1));
		prog.push_back(addi_instr(5'd14, 5'd0, 12'd2));
		prog.push_back(addi_instr(5'd0, 5'd0, 12'd7));
		prog.push_back(rtype_instr(7'b0000000, 3'b000, 5'd15, 5'd12, 5'd0));
		prog.push_back(sw_instr(5'd15, 5'd0, 12'd12));

		expect_wb("addi x1", 5'd1, a);
		expect_wb("addi x2", 5'd2, b);
		expect_wb("add fwd", 5'd3, a + b);
		expect_wb("sub fwd", 5'd4, (a + b) - a);
		expect_wb("and", 5'd5, a & b);
		expect_wb("or", 5'd6, a | b);
		expect_wb("xor", 5'd7, a ^ b);
		// b is negative and a is not
		expect_wb("slt neg<pos", 5'd8, 32'd1);
		expect_wb("slt pos<neg", 5'd9, 32'd0);
		expect_store("sw", 32'd8, a + b);
		expect_wb("lw", 5'd10, a + b);
		expect_wb("load use", 5'd11, (a + b) + a);
		expect_wb("after beq not taken", 5'd12, 32'd5);
		expect_wb("x0 read", 5'd15, 32'd5);
		expect_store("sw after branch", 32'd12, 32'd5);
		prog_n = prog.size();
	endtask

	task automatic check_wb(input string name, input reg_addr_t exp_rd, input word_t exp_data);
		if (wb_rd !== exp_rd || wb_data !== exp_data) begin
			err_count++;
			$display("FAIL %s: expected x%0d = %h, actual x%0d = %h",
				name, exp_rd, exp_data, wb_rd, wb_data);
			$display("TEST RESULT: FAIL");
			$fatal(1, "register write mismatch");
		end
	endtask

	task automatic check_store(input string name, input pc_t exp_addr, input word_t exp_data);
		if (st_addr !== exp_addr || st_data !== exp_data) begin
			err_count++;
			$display("FAIL %s: expected [%h] = %h, actual [%h] = %h",
				name, exp_addr, exp_data, st_addr, st_data);
			$display("TEST RESULT: FAIL");
			$fatal(1, "store mismatch");
		end
	endtask

	task automatic report_stray(input string what);
		err_count++;
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "event out of order");
	endtask

	initial begin
		int idx;
		clk        = 1'b0;
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		build_tests();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// load with the core halted
		for (int i = 0; i < prog_n; i++) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = imem_idx_t'(i);
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		@(negedge clk);
		run = 1'b1;

		// a writeback is always older than a store seen in the same cycle
		idx = 0;
		while (idx < exp_val.size()) begin
			@(negedge clk);
			if (wb_valid) begin
				if (idx >= exp_val.size() || exp_is_store[idx]) begin
					report_stray($sformatf("register write to x%0d came where none was expected",
						wb_rd));
				end
				check_wb(exp_name[idx], reg_addr_t'(exp_key[idx]), exp_val[idx]);
				idx++;
			end
			if (st_valid) begin
				if (idx >= exp_val.size() || !exp_is_store[idx]) begin
					report_stray($sformatf("store to %h came where none was expected", st_addr));
				end
				check_store(exp_name[idx], exp_key[idx], exp_val[idx]);
				idx++;
			end
		end

		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

	// reset, load, then 8 cycles per program word and some slack
	initial begin
		int limit;
		wait (prog_n != 0);
		limit = 10 + prog_n + prog_n * 8 + 50;
		repeat (limit) @(posedge clk);
		$display("timeout: the expected events did not all appear within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu (
	input  core_types_pkg::word_t a_i,
	input  core_types_pkg::word_t b_i,
	input  rv_isa_pkg::alu_op_e   op_i,
	output core_types_pkg::word_t y_o,
	output logic                  zero_o
);
	import rv_isa_pkg::*;

	always_comb begin
		case (op_i)
			ALU_ADD: y_o = a_i + b_i;
			ALU_SUB: y_o = a_i - b_i;
			ALU_AND: y_o = a_i & b_i;
			ALU_OR:  y_o = a_i | b_i;
			ALU_XOR: y_o = a_i ^ b_i;
			// signed compare
			ALU_SLT: y_o = {31'b0, $signed(a_i) < $signed(b_i)};
			default: y_o = '0;
		endcase
	end

	// beq taken when a - b is zero
	assign zero_o = (y_o == '0);

endmodule

/* rtl/core.sv */
`timescale 1ns/1ns

module core (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      run_i,
	input  logic                      imem_we_i,
	input  core_types_pkg::imem_idx_t imem_addr_i,
	input  core_types_pkg::word_t     imem_wdata_i,
	output logic                      wb_valid_o,
	output core_types_pkg::reg_addr_t wb_rd_o,
	output core_types_pkg::word_t     wb_data_o,
	output logic                      st_valid_o,
	output core_types_pkg::pc_t       st_addr_o,
	output core_types_pkg::word_t     st_data_o
);
	import core_types_pkg::*;
	import rv_isa_pkg::*;

	pc_t       pc_q;
	word_t     fetch_instr;
	logic      ifid_valid;
	pc_t       ifid_pc;
	word_t     ifid_instr;
	logic      dec_reg_we, dec_mem_re, dec_mem_we, dec_mem_to_reg, dec_alu_src, dec_is_branch;
	alu_op_e   dec_alu_op;
	word_t     dec_imm, rf_rdata1, rf_rdata2;
	logic      id_keep;
	logic      idex_valid, idex_reg_we, idex_mem_re, idex_mem_we;
	logic      idex_mem_to_reg, idex_alu_src, idex_is_branch;
	alu_op_e   idex_alu_op;
	pc_t       idex_pc;
	reg_addr_t idex_rs1, idex_rs2, idex_rd;
	word_t     idex_rdata1, idex_rdata2, idex_imm;
	logic [1:0] fwd_a, fwd_b;
	logic      stall, flush, alu_zero, branch_taken;
	word_t     ex_a, ex_b_fwd, ex_y;
	pc_t       branch_target;
	logic      exmem_valid, exmem_reg_we, exmem_mem_we, exmem_mem_to_reg;
	reg_addr_t exmem_rd;
	word_t     exmem_alu_y, exmem_store_data, mem_rdata;
	logic      memwb_valid, memwb_reg_we, memwb_mem_to_reg;
	reg_addr_t memwb_rd;
	word_t     memwb_alu_y, memwb_mem_data, wb_data;

	// fetch
	instr_mem i_instr_mem (
		.clk     (clk),
		.we_i    (imem_we_i),
		.waddr_i (imem_addr_i),
		.wdata_i (imem_wdata_i),
		.raddr_i (imem_idx_t'(pc_q[31:2])),
		.rdata_o (fetch_instr)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q       <= '0;
			ifid_valid <= 1'b0;
			ifid_pc    <= '0;
			ifid_instr <= '0;
		end else if (run_i) begin
			if (flush) begin
				pc_q       <= branch_target;
				ifid_valid <= 1'b0;
				ifid_instr <= '0;
			end else if (!stall) begin
				pc_q       <= pc_q + 32'd4;
				ifid_valid <= 1'b1;
				ifid_pc    <= pc_q;
				ifid_instr <= fetch_instr;
			end
		end
	end

	// decode
	decoder i_decoder (
		.instr_i      (ifid_instr),
		.reg_we_o     (dec_reg_we),
		.mem_re_o     (dec_mem_re),
		.mem_we_o     (dec_mem_we),
		.mem_to_reg_o (dec_mem_to_reg),
		.alu_src_o    (dec_alu_src),
		.is_branch_o  (dec_is_branch),
		.alu_op_o     (dec_alu_op),
		.imm_o        (dec_imm)
	);

	regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_i    (ifid_instr[19:15]),
		.rs2_i    (ifid_instr[24:20]),
		.rd_i     (memwb_rd),
		.we_i     (memwb_reg_we && run_i),
		.wdata_i  (wb_data),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2)
	);

	hazard_unit i_hazard_unit (
		.ifid_rs1_i     (ifid_instr[19:15]),
		.ifid_rs2_i     (ifid_instr[24:20]),
		.idex_rs1_i     (idex_rs1),
		.idex_rs2_i     (idex_rs2),
		.idex_rd_i      (idex_rd),
		.exmem_rd_i     (exmem_rd),
		.memwb_rd_i     (memwb_rd),
		.idex_mem_re_i  (idex_mem_re),
		.exmem_reg_we_i (exmem_reg_we),
		.memwb_reg_we_i (memwb_reg_we),
		.branch_taken_i (branch_taken),
		.fwd_a_o        (fwd_a),
		.fwd_b_o        (fwd_b),
		.stall_o        (stall),
		.flush_o        (flush)
	);

	// bubble into id/ex on stall or flush
	assign id_keep = ifid_valid && !flush && !stall;

	// control bits of the three later stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex_valid       <= 1'b0;
			idex_reg_we      <= 1'b0;
			idex_mem_re      <= 1'b0;
			idex_mem_we      <= 1'b0;
			idex_mem_to_reg  <= 1'b0;
			idex_alu_src     <= 1'b0;
			idex_is_branch   <= 1'b0;
			exmem_valid      <= 1'b0;
			exmem_reg_we     <= 1'b0;
			exmem_mem_we     <= 1'b0;
			exmem_mem_to_reg <= 1'b0;
			memwb_valid      <= 1'b0;
			memwb_reg_we     <= 1'b0;
			memwb_mem_to_reg <= 1'b0;
		end else if (run_i) begin
			idex_valid       <= id_keep;
			idex_reg_we      <= id_keep && dec_reg_we;
			idex_mem_re      <= id_keep && dec_mem_re;
			idex_mem_we      <= id_keep && dec_mem_we;
			idex_mem_to_reg  <= id_keep && dec_mem_to_reg;
			idex_alu_src     <= id_keep && dec_alu_src;
			idex_is_branch   <= id_keep && dec_is_branch;
			exmem_valid      <= idex_valid;
			exmem_reg_we     <= idex_reg_we;
			exmem_mem_we     <= idex_mem_we;
			exmem_mem_to_reg <= idex_mem_to_reg;
			memwb_valid      <= exmem_valid;
			memwb_reg_we     <= exmem_reg_we;
			memwb_mem_to_reg <= exmem_mem_to_reg;
		end
	end

	// payload, only meaningful while the matching valid bit is set
	always_ff @(posedge clk) begin
		if (run_i) begin
			idex_alu_op      <= dec_alu_op;
			idex_pc          <= ifid_pc;
			idex_rs1         <= ifid_instr[19:15];
			idex_rs2         <= ifid_instr[24:20];
			idex_rd          <= ifid_instr[11:7];
			idex_rdata1      <= rf_rdata1;
			idex_rdata2      <= rf_rdata2;
			idex_imm         <= dec_imm;
			exmem_rd         <= idex_rd;
			exmem_alu_y      <= ex_y;
			exmem_store_data <= ex_b_fwd;
			memwb_rd         <= exmem_rd;
			memwb_alu_y      <= exmem_alu_y;
			memwb_mem_data   <= mem_rdata;
		end
	end

	// execute with forwarding
	always_comb begin
		case (fwd_a)
			2'b10:   ex_a = exmem_alu_y;
			2'b01:   ex_a = wb_data;
			default: ex_a = idex_rdata1;
		endcase
		case (fwd_b)
			2'b10:   ex_b_fwd = exmem_alu_y;
			2'b01:   ex_b_fwd = wb_data;
			default: ex_b_fwd = idex_rdata2;
		endcase
	end

	alu i_alu (
		.a_i    (ex_a),
		.b_i    (idex_alu_src ? idex_imm : ex_b_fwd),
		.op_i   (idex_alu_op),
		.y_o    (ex_y),
		.zero_o (alu_zero)
	);

	assign branch_taken  = idex_is_branch && alu_zero;
	assign branch_target = idex_pc + idex_imm;

	// memory
	data_mem i_data_mem (
		.clk     (clk),
		.we_i    (exmem_mem_we && run_i),
		.idx_i   (dmem_idx_t'(exmem_alu_y[31:2])),
		.wdata_i (exmem_store_data),
		.rdata_o (mem_rdata)
	);

	assign st_valid_o = run_i && exmem_valid && exmem_mem_we;
	assign st_addr_o  = exmem_alu_y;
	assign st_data_o  = exmem_store_data;

	// writeback
	assign wb_data    = memwb_mem_to_reg ? memwb_mem_data : memwb_alu_y;
	assign wb_valid_o = run_i && memwb_valid && memwb_reg_we && (memwb_rd != '0);
	assign wb_rd_o    = memwb_rd;
	assign wb_data_o  = wb_data;

endmodule

/* rtl/core_types_pkg.sv */
package core_types_pkg;

	// memory depths in words
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// byte address
	typedef logic [31:0] pc_t;

	// word indices into the two rams
	typedef logic [$clog2(IMEM_WORDS)-1:0] imem_idx_t;
	typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_idx_t;

endpackage

/* rtl/data_mem.sv */
`timescale 1ns/1ns

module data_mem (
	input  logic                      clk,
	input  logic                      we_i,
	input  core_types_pkg::dmem_idx_t idx_i,
	input  core_types_pkg::word_t     wdata_i,
	output core_types_pkg::word_t     rdata_o
);
	import core_types_pkg::*;

	word_t mem [DMEM_WORDS];

	// data starts out as zero
	initial begin
		for (int i = 0; i < DMEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[idx_i] <= wdata_i;
		end
	end

	// loads see the array directly
	assign rdata_o = mem[idx_i];

endmodule

/* rtl/decoder.sv */
`timescale 1ns/1ns

module decoder (
	input  core_types_pkg::word_t instr_i,
	output logic                  reg_we_o,
	output logic                  mem_re_o,
	output logic                  mem_we_o,
	output logic                  mem_to_reg_o,
	output logic                  alu_src_o,
	output logic                  is_branch_o,
	output rv_isa_pkg::alu_op_e   alu_op_o,
	output core_types_pkg::word_t imm_o
);
	import rv_isa_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_b5;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign f7_b5  = instr_i[30];

	always_comb begin
		reg_we_o     = 1'b0;
		mem_re_o     = 1'b0;
		mem_we_o     = 1'b0;
		mem_to_reg_o = 1'b0;
		alu_src_o    = 1'b0;
		is_branch_o  = 1'b0;
		alu_op_o     = ALU_ADD;
		imm_o        = '0;
		case (opcode)
			OP_RTYPE: begin
				reg_we_o = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op_o = f7_b5 ? ALU_SUB : ALU_ADD;
					F3_SLT:     alu_op_o = ALU_SLT;
					F3_XOR:     alu_op_o = ALU_XOR;
					F3_OR:      alu_op_o = ALU_OR;
					F3_AND:     alu_op_o = ALU_AND;
					default:    reg_we_o = 1'b0;
				endcase
			end
			OP_ITYPE: begin
				// only addi
				reg_we_o  = (funct3 == F3_ADD_SUB);
				alu_src_o = 1'b1;
				imm_o     = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			OP_LOAD: begin
				reg_we_o     = (funct3 == F3_WORD);
				mem_re_o     = (funct3 == F3_WORD);
				mem_to_reg_o = 1'b1;
				alu_src_o    = 1'b1;
				imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			OP_STORE: begin
				mem_we_o  = (funct3 == F3_WORD);
				alu_src_o = 1'b1;
				imm_o     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
			end
			OP_BRANCH: begin
				// beq compares through a subtract
				is_branch_o = (funct3 == F3_BEQ);
				alu_op_o    = ALU_SUB;
				imm_o       = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
					instr_i[30:25], instr_i[11:8], 1'b0};
			end
			default: begin
				alu_op_o = ALU_ADD;
			end
		endcase
	end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
	input  core_types_pkg::reg_addr_t ifid_rs1_i,
	input  core_types_pkg::reg_addr_t ifid_rs2_i,
	input  core_types_pkg::reg_addr_t idex_rs1_i,
	input  core_types_pkg::reg_addr_t idex_rs2_i,
	input  core_types_pkg::reg_addr_t idex_rd_i,
	input  core_types_pkg::reg_addr_t exmem_rd_i,
	input  core_types_pkg::reg_addr_t memwb_rd_i,
	input  logic                      idex_mem_re_i,
	input  logic                      exmem_reg_we_i,
	input  logic                      memwb_reg_we_i,
	input  logic                      branch_taken_i,
	output logic [1:0]                fwd_a_o,
	output logic [1:0]                fwd_b_o,
	output logic                      stall_o,
	output logic                      flush_o
);
	import core_types_pkg::*;

	logic load_use;

	// 2'b10 from ex/mem, 2'b01 from mem/wb, 2'b00 from the regfile
	function automatic logic [1:0] fwd_sel(input reg_addr_t rs, input reg_addr_t exmem_rd,
			input logic exmem_we, input reg_addr_t memwb_rd, input logic memwb_we);
		if (exmem_we && exmem_rd != '0 && exmem_rd == rs) begin
			return 2'b10;
		end else if (memwb_we && memwb_rd != '0 && memwb_rd == rs) begin
			return 2'b01;
		end
		return 2'b00;
	endfunction

	always_comb begin
		fwd_a_o = fwd_sel(idex_rs1_i, exmem_rd_i, exmem_reg_we_i, memwb_rd_i, memwb_reg_we_i);
		fwd_b_o = fwd_sel(idex_rs2_i, exmem_rd_i, exmem_reg_we_i, memwb_rd_i, memwb_reg_we_i);
	end

	// load in ex feeding the instruction in id
	assign load_use = idex_mem_re_i && (idex_rd_i != '0)
		&& (idex_rd_i == ifid_rs1_i || idex_rd_i == ifid_rs2_i);

	assign flush_o = branch_taken_i;
	assign stall_o = load_use && !branch_taken_i;

endmodule

/* rtl/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem (
	input  logic                      clk,
	input  logic                      we_i,
	input  core_types_pkg::imem_idx_t waddr_i,
	input  core_types_pkg::word_t     wdata_i,
	input  core_types_pkg::imem_idx_t raddr_i,
	output core_types_pkg::word_t     rdata_o
);
	import core_types_pkg::*;

	word_t mem [IMEM_WORDS];

	// power-up contents are zero, an all-zero word decodes as a bubble
	initial begin
		for (int i = 0; i < IMEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// program load port
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	assign rdata_o = mem[raddr_i];

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ns

module regfile (
	input  logic                      clk,
	input  logic                      rst_n,
	input  core_types_pkg::reg_addr_t rs1_i,
	input  core_types_pkg::reg_addr_t rs2_i,
	input  core_types_pkg::reg_addr_t rd_i,
	input  logic                      we_i,
	input  core_types_pkg::word_t     wdata_i,
	output core_types_pkg::word_t     rdata1_o,
	output core_types_pkg::word_t     rdata2_o
);
	import core_types_pkg::*;

	word_t regs [32];
	logic  wr_en;

	// x0 is never written
	assign wr_en = we_i && (rd_i != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// bypass the write of this cycle to the readers
	assign rdata1_o = (wr_en && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
	assign rdata2_o = (wr_en && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	// funct3 for register and immediate ops
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for word loads, stores and beq
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [2:0] F3_BEQ  = 3'b000;

	// operations the alu knows
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

endpackage

/* tb.f */
rtl/core_types_pkg.sv
rtl/rv_isa_pkg.sv
rtl/instr_mem.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/hazard_unit.sv
rtl/core.sv
dv/core_properties.sv
dv/core_tb.sv
